//--- project.f
common/fp_format_pkg.sv
common/fpm_pipe_pkg.sv
common/fpm_stage_if.sv
multiplier/fpm_classify_stage.sv
multiplier/fpm_product_stage.sv
multiplier/fpm_normalize.sv
source/fpm_top.sv
tests/fpm_checker.sv
tests/fpm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiplier regression with Verilator and runs it
# The log is searched for the pass line to decide the exit status

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module fpm_tb -o fpm_sim \
    && ./obj_dir/fpm_sim | tee sim.log \
    || { echo "Build or simulation step did not complete"; exit 1; }

grep -q "^Regression passed$" sim.log && exit 0 || exit 1

//--- tests/fpm_tb.sv
// ----------------------------------------
// Multiplier testbench
// Directed operand table with hand-worked
// results, reset, drain and timeout
// ----------------------------------------

`timescale 1ns/1ps

module fpm_tb
    import fp_format_pkg::*;
();

    localparam int TABLE_LEN = 24;
    localparam int RESET_CYCLES = 5;
    // Reset, up to two cycles per entry, then slack for the drain
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * TABLE_LEN + 20;

    // Flags are invalid, inexact, overflow, underflow from the top
    typedef struct packed {
        float32_t    a;
        float32_t    b;
        logic        valid;
        float32_t    result;
        logic [3:0]  flags;
        round_bits_t rb;
    } entry_t;

    logic        clk;
    logic        rst_n;
    float32_t    multiplicand;
    float32_t    multiplier;
    logic        data_valid_in;
    float32_t    result;
    logic        data_valid_out;
    logic        invalid_op;
    logic        inexact;
    logic        overflow;
    logic        underflow;
    round_bits_t round_bits;

    // Expected side, handed to the checker with the operands
    logic        exp_valid;
    float32_t    exp_result;
    logic [3:0]  exp_flags;
    round_bits_t exp_rb;

    int value_errors;
    int protocol_errors;
    int checked_count;
    int resolved_count;

    entry_t stim_q[$];
    int     sent_count = 0;
    int     cycle_count = 0;

    // ----------------------------------------
    // DUT and checker
    // ----------------------------------------

    fpm_top fpm_top_inst (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .multiplicand_i (multiplicand),
        .multiplier_i   (multiplier),
        .data_valid_i   (data_valid_in),
        .result_o       (result),
        .data_valid_o   (data_valid_out),
        .invalid_op_o   (invalid_op),
        .inexact_o      (inexact),
        .overflow_o     (overflow),
        .underflow_o    (underflow),
        .round_bits_o   (round_bits)
    );

    fpm_checker fpm_checker_inst (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .exp_valid_i       (exp_valid),
        .exp_result_i      (exp_result),
        .exp_flags_i       (exp_flags),
        .exp_round_bits_i  (exp_rb),
        .result_i          (result),
        .data_valid_i      (data_valid_out),
        .invalid_op_i      (invalid_op),
        .inexact_i         (inexact),
        .overflow_i        (overflow),
        .underflow_i       (underflow),
        .round_bits_i      (round_bits),
        .value_errors_o    (value_errors),
        .protocol_errors_o (protocol_errors),
        .checked_count_o   (checked_count),
        .resolved_count_o  (resolved_count)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    task automatic add_entry(input float32_t a, input float32_t b, input logic valid,
                             input float32_t res, input logic [3:0] flags,
                             input round_bits_t rb);
        entry_t e;
        e.a      = a;
        e.b      = b;
        e.valid  = valid;
        e.result = res;
        e.flags  = flags;
        e.rb     = rb;
        stim_q.push_back(e);
    endtask

    task automatic load_table;
        // Plain products, no carry and carry into bit 47
        add_entry(32'h3FC0_0000, 32'h3FA0_0000, 1'b1, 32'h3FF0_0000, 4'b0000, 3'b000);
        add_entry(32'h3FE0_0000, 32'h3FE0_0000, 1'b1, 32'h4044_0000, 4'b0000, 3'b000);
        add_entry(32'h3F80_0000, 32'h3F80_0000, 1'b0, 32'h0000_0000, 4'b0000, 3'b000);
        // Nonzero tails, guard round sticky patterns
        add_entry(32'h3FFF_FFFF, 32'h3FFF_FFFF, 1'b1, 32'h407F_FFFE, 4'b0100, 3'b001);
        add_entry(32'h3F80_0001, 32'h3FFF_FFFF, 1'b1, 32'h4000_0000, 4'b0100, 3'b011);
        add_entry(32'h3FC0_0001, 32'h3FC0_0000, 1'b1, 32'h4010_0000, 4'b0100, 3'b110);
        add_entry(32'h3F80_0001, 32'h3FC0_0000, 1'b1, 32'h3FC0_0001, 4'b0100, 3'b100);
        add_entry(32'h4040_0000, 32'hBF00_0000, 1'b1, 32'hBFC0_0000, 4'b0000, 3'b000);
        add_entry(32'h3F80_0000, 32'h3F80_0000, 1'b0, 32'h0000_0000, 4'b0000, 3'b000);
        // Largest finite, then overflow by sum, by carry, and far out
        add_entry(32'h7F00_0000, 32'h3F80_0000, 1'b1, 32'h7F00_0000, 4'b0000, 3'b000);
        add_entry(32'h7F00_0000, 32'h4000_0000, 1'b1, 32'h7F80_0000, 4'b0010, 3'b000);
        add_entry(32'hFF60_0000, 32'h3FE0_0000, 1'b1, 32'hFF80_0000, 4'b0010, 3'b000);
        add_entry(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b1, 32'h7F80_0000, 4'b0110, 3'b001);
        // Subnormal results, shifts of 1, 1, 11, 23, 24 and saturated
        add_entry(32'h1F80_0000, 32'h2000_0000, 1'b1, 32'h0040_0000, 4'b0000, 3'b000);
        add_entry(32'h1FC0_0000, 32'h2000_0001, 1'b1, 32'h0060_0000, 4'b0100, 3'b110);
        add_entry(32'h9D00_0000, 32'h1DC0_0000, 1'b1, 32'h8000_1800, 4'b0000, 3'b000);
        add_entry(32'h1A00_0000, 32'h1AC0_0000, 1'b1, 32'h0000_0001, 4'b0100, 3'b100);
        add_entry(32'h1A00_0000, 32'h1A40_0000, 1'b1, 32'h0000_0000, 4'b0101, 3'b110);
        add_entry(32'h0080_0000, 32'h8080_0000, 1'b1, 32'h8000_0000, 4'b0101, 3'b001);
        // Carry lifts a zero exponent back to the smallest normal
        add_entry(32'h1FE0_0000, 32'h2060_0000, 1'b1, 32'h00C4_0000, 4'b0000, 3'b000);
        // NaN, infinity, zero, subnormal operands
        add_entry(32'h7FC0_0000, 32'h3F80_0000, 1'b1, 32'h0000_0000, 4'b1000, 3'b000);
        add_entry(32'h7F80_0000, 32'h4000_0000, 1'b1, 32'h0000_0000, 4'b1000, 3'b000);
        add_entry(32'h0000_0000, 32'h3FC0_0000, 1'b1, 32'h0000_0000, 4'b1000, 3'b000);
        add_entry(32'h3FA0_0000, 32'h0000_0001, 1'b1, 32'h0000_0000, 4'b1000, 3'b000);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        multiplicand  = '0;
        multiplier    = '0;
        data_valid_in = 1'b0;
        exp_valid     = 1'b0;
        exp_result    = '0;
        exp_flags     = '0;
        exp_rb        = '0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // One entry per edge, valid gaps come from the table
        foreach (stim_q[i]) begin
            @(posedge clk);
            multiplicand  <= stim_q[i].a;
            multiplier    <= stim_q[i].b;
            data_valid_in <= stim_q[i].valid;
            exp_valid     <= stim_q[i].valid;
            exp_result    <= stim_q[i].result;
            exp_flags     <= stim_q[i].flags;
            exp_rb        <= stim_q[i].rb;
            if (stim_q[i].valid) begin
                sent_count++;
            end
        end
        @(posedge clk);
        data_valid_in <= 1'b0;
        exp_valid     <= 1'b0;

        // Drain until every sent pair has been answered or missed
        while (resolved_count < sent_count) begin
            @(posedge clk);
        end

        $display("Checked %0d of %0d results, %0d value errors, %0d protocol errors",
                 checked_count, sent_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0 && checked_count == sent_count) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : fpm_tb

//--- tests/fpm_checker.sv
// ----------------------------------------
// Multiplier result checker
// Delays the expected values by the DUT
// latency and compares every output field
// ----------------------------------------

`timescale 1ns/1ps

module fpm_checker
    import fp_format_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    // Expected values, driven in step with the operands
    input  logic        exp_valid_i,
    input  float32_t    exp_result_i,
    input  logic [3:0]  exp_flags_i,
    input  round_bits_t exp_round_bits_i,
    // DUT outputs
    input  float32_t    result_i,
    input  logic        data_valid_i,
    input  logic        invalid_op_i,
    input  logic        inexact_i,
    input  logic        overflow_i,
    input  logic        underflow_i,
    input  round_bits_t round_bits_i,
    // Counts for the closing summary
    output int          value_errors_o,
    output int          protocol_errors_o,
    output int          checked_count_o,
    output int          resolved_count_o
);

    // Flag order is invalid, inexact, overflow, underflow
    logic        valid_d1;
    logic        valid_d2;
    float32_t    result_d1;
    float32_t    result_d2;
    logic [3:0]  flags_d1;
    logic [3:0]  flags_d2;
    round_bits_t rb_d1;
    round_bits_t rb_d2;

    int value_errors = 0;
    int protocol_errors = 0;
    int checked_count = 0;
    int resolved_count = 0;

    assign value_errors_o    = value_errors;
    assign protocol_errors_o = protocol_errors;
    assign checked_count_o   = checked_count;
    assign resolved_count_o  = resolved_count;

    // ----------------------------------------
    // Two-cycle delay line, matches the DUT
    // ----------------------------------------

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= exp_valid_i;
            valid_d2 <= valid_d1;
        end
        result_d1 <= exp_result_i;
        result_d2 <= result_d1;
        flags_d1  <= exp_flags_i;
        flags_d2  <= flags_d1;
        rb_d1     <= exp_round_bits_i;
        rb_d2     <= rb_d1;
    end

    // ----------------------------------------
    // Comparison
    // ----------------------------------------

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_result;
        check_field("invalid_op_o", 32'(flags_d2[3]), 32'(invalid_op_i));
        // Rejected pairs carry no meaningful result
        if (!flags_d2[3]) begin
            check_field("result_o", result_d2, result_i);
            check_field("inexact_o", 32'(flags_d2[2]), 32'(inexact_i));
            check_field("overflow_o", 32'(flags_d2[1]), 32'(overflow_i));
            check_field("underflow_o", 32'(flags_d2[0]), 32'(underflow_i));
            check_field("round_bits_o", 32'(rb_d2), 32'(round_bits_i));
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if ($isunknown(data_valid_i)) begin
                $display("data_valid_o went unknown at %0d ns", $time);
                protocol_errors++;
            end else if (data_valid_i && !valid_d2) begin
                $display("A result appeared at %0d ns with no operand pair behind it", $time);
                protocol_errors++;
            end else if (!data_valid_i && valid_d2) begin
                $display("A result due at %0d ns never arrived", $time);
                protocol_errors++;
            end else if (data_valid_i) begin
                compare_result();
                checked_count++;
            end
            if (valid_d2) begin
                resolved_count++;
            end
        end
    end

endmodule : fpm_checker

//--- source/fpm_top.sv
// ----------------------------------------
// Pipelined single-precision multiplier
// Normal operands only, two-cycle latency,
// truncated result plus round bits
// ----------------------------------------

`timescale 1ns/1ps

module fpm_top
    import fp_format_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Operand pair, one per cycle
    input  float32_t    multiplicand_i,
    input  float32_t    multiplier_i,
    input  logic        data_valid_i,

    // Result, valid two cycles after the operands
    output float32_t    result_o,
    output logic        data_valid_o,

    // Exception flags
    output logic        invalid_op_o,
    output logic        inexact_o,
    output logic        overflow_o,
    output logic        underflow_o,

    // Guard, round and sticky for a later rounding step
    output round_bits_t round_bits_o
);

    // Stage buses
    fpm_stage0_if stage0_if ();
    fpm_stage1_if stage1_if ();

    // Stage 0, classification, sign and exponent sum
    fpm_classify_stage classify_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .data_valid_i   (data_valid_i),
        .stage_o        (stage0_if.source)
    );

    // Stage 1, significand multiply
    fpm_product_stage product_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stage_i (stage0_if.sink),
        .stage_o (stage1_if.source)
    );

    // Output logic, normalize and flag
    fpm_normalize normalize_inst (
        .stage_i      (stage1_if.sink),
        .result_o     (result_o),
        .data_valid_o (data_valid_o),
        .invalid_op_o (invalid_op_o),
        .inexact_o    (inexact_o),
        .overflow_o   (overflow_o),
        .underflow_o  (underflow_o),
        .round_bits_o (round_bits_o)
    );

endmodule : fpm_top

//--- multiplier/fpm_normalize.sv
// ----------------------------------------
// Output normalizer
// Aligns the product, handles overflow and
// subnormal results, extracts round bits
// ----------------------------------------

`timescale 1ns/1ps

module fpm_normalize
    import fp_format_pkg::*;
    import fpm_pipe_pkg::*;
(
    fpm_stage1_if.sink  stage_i,
    output float32_t    result_o,
    output logic        data_valid_o,
    output logic        invalid_op_o,
    output logic        inexact_o,
    output logic        overflow_o,
    output logic        underflow_o,
    output round_bits_t round_bits_o
);

    // Product with the leading one moved to bit 47
    product_t   mant;
    // Exponent after the carry adjust
    exp_work_t  exp_norm;
    // Right shift a subnormal result would need
    exp_work_t  shift_full;
    logic [4:0] shift_amt;
    // Aligned product plus room for bits shifted past the tail
    logic [PROD_W+SIG_W+1:0] aligned;

    // ----------------------------------------
    // Normalization
    // ----------------------------------------

    // Carry into bit 47 means the value is 2.x, bump the exponent
    assign mant = stage_i.product[PROD_W-1] ? stage_i.product
                                            : {stage_i.product[PROD_W-2:0], 1'b0};
    assign exp_norm = stage_i.product[PROD_W-1] ? stage_i.exponent + exp_work_t'(1)
                                                : stage_i.exponent;

    assign shift_full = exp_work_t'(1) - exp_norm;

    // Beyond SIG_W + 2 places the hidden bit is already inside the sticky range
    always_comb begin
        if (exp_norm > exp_work_t'(0)) begin
            shift_amt = '0;
        end else if (shift_full > exp_work_t'(SIG_W + 2)) begin
            shift_amt = 5'(SIG_W + 2);
        end else begin
            shift_amt = shift_full[4:0];
        end
    end

    assign aligned = {mant, {(SIG_W + 2){1'b0}}} >> shift_amt;

    // ----------------------------------------
    // Result fields and flags
    // ----------------------------------------

    always_comb begin
        result_o.sign        = stage_i.sign;
        result_o.significand = aligned[PROD_W+SIG_W -: MANT_W];
        result_o.exponent    = exp_norm[EXP_W-1:0];
        overflow_o           = 1'b0;
        underflow_o          = 1'b0;

        if (exp_norm >= EXP_MAX) begin
            // Too large, saturate to infinity
            result_o.exponent    = '1;
            result_o.significand = '0;
            overflow_o           = 1'b1;
        end else if (exp_norm <= 0) begin
            // Subnormal encoding, fraction already shifted
            result_o.exponent = '0;
            // No fraction bits left at all
            underflow_o = (shift_full >= SIG_W);
        end

        if (stage_i.valid) begin
            assert (!(overflow_o && underflow_o))
            else $error("fpm_normalize: overflow and underflow both set");
        end
    end

    // Bits just below the stored significand, the rest folds into sticky
    assign round_bits_o.guard  = aligned[PROD_W+1];
    assign round_bits_o.round  = aligned[PROD_W];
    assign round_bits_o.sticky = |aligned[PROD_W-1:0];

    assign inexact_o    = |round_bits_o;
    assign invalid_op_o = stage_i.invalid;
    assign data_valid_o = stage_i.valid;

endmodule : fpm_normalize

//--- multiplier/fpm_product_stage.sv
// ----------------------------------------
// Significand product stage
// One 24 x 24 multiply, registered with
// the sign, exponent and invalid flag
// ----------------------------------------

`timescale 1ns/1ps

module fpm_product_stage
    import fpm_pipe_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    fpm_stage0_if.sink   stage_i,
    fpm_stage1_if.source stage_o
);

    // ----------------------------------------
    // Multiply
    // ----------------------------------------

    // 1.x times 1.x lands in [1, 4)
    // so the product has its top one in bit 47 or bit 46
    product_t product;

    assign product = stage_i.multiplicand_sig * stage_i.multiplier_sig;

    // ----------------------------------------
    // Stage 1 register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end else begin
            stage_o.valid <= stage_i.valid;
        end
    end

    // Side fields travel alongside the product unchanged
    always_ff @(posedge clk_i) begin
        stage_o.product  <= product;
        stage_o.sign     <= stage_i.sign;
        stage_o.invalid  <= stage_i.invalid;
        stage_o.exponent <= stage_i.exponent;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Normal operands from the classifier always give a normalizable product
    product_msb_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stage_o.valid && !stage_o.invalid)
        |-> (stage_o.product[PROD_W-1] || stage_o.product[PROD_W-2]));

endmodule : fpm_product_stage

//--- multiplier/fpm_classify_stage.sv
// ----------------------------------------
// Operand classification stage
// Flags non-normal operands, forms sign,
// exponent sum and significands
// ----------------------------------------

`timescale 1ns/1ps

module fpm_classify_stage
    import fp_format_pkg::*;
    import fpm_pipe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  float32_t multiplicand_i,
    input  float32_t multiplier_i,
    input  logic     data_valid_i,
    fpm_stage0_if.source stage_o
);

    // Exponent field decides first and the significand splits the pairs
    function automatic operand_class_e classify(input float32_t op);
        operand_class_e cls;
        if (op.exponent == '1) begin
            if (op.significand == '0) begin
                cls = CLASS_INFINITY;
            end else begin
                cls = CLASS_NAN;
            end
        end else if (op.exponent == '0) begin
            if (op.significand == '0) begin
                cls = CLASS_ZERO;
            end else begin
                cls = CLASS_SUBNORMAL;
            end
        end else begin
            cls = CLASS_NORMAL;
        end
        return cls;
    endfunction

    // ----------------------------------------
    // Combinational front end
    // ----------------------------------------

    operand_class_e mcand_class;
    operand_class_e mplier_class;
    logic           invalid;
    exp_work_t      exp_sum;

    assign mcand_class  = classify(multiplicand_i);
    assign mplier_class = classify(multiplier_i);

    // Anything but two normals is rejected
    assign invalid = (mcand_class != CLASS_NORMAL) || (mplier_class != CLASS_NORMAL);

    // Both biases are in the sum so one is removed
    assign exp_sum = exp_work_t'({2'b00, multiplicand_i.exponent})
                   + exp_work_t'({2'b00, multiplier_i.exponent})
                   - exp_work_t'(BIAS);

    // ----------------------------------------
    // Stage 0 register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end else begin
            stage_o.valid <= data_valid_i;
        end
    end

    // Hidden bit forced on since only normals are meaningful
    always_ff @(posedge clk_i) begin
        stage_o.sign             <= multiplicand_i.sign ^ multiplier_i.sign;
        stage_o.invalid          <= invalid;
        stage_o.exponent         <= exp_sum;
        stage_o.multiplicand_sig <= {1'b1, multiplicand_i.significand};
        stage_o.multiplier_sig   <= {1'b1, multiplier_i.significand};
    end

    // Valid never goes unknown once reset has been seen
    valid_known_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(stage_o.valid));

endmodule : fpm_classify_stage

//--- common/fpm_stage_if.sv
// ----------------------------------------
// Stage-to-stage buses of the multiplier
// Stage 0 carries classified operands,
// stage 1 carries the raw product
// ----------------------------------------

`timescale 1ns/1ps

// ----------------------------------------
// Classify stage to product stage
// ----------------------------------------
interface fpm_stage0_if
    import fp_format_pkg::*;
    import fpm_pipe_pkg::*;
();

    // One item per cycle, no back-pressure
    logic             valid;
    logic             sign;
    // Either operand was not a normal number
    logic             invalid;
    // ea + eb - bias, before normalization
    exp_work_t        exponent;
    // Significands with the hidden bit set
    logic [SIG_W-1:0] multiplicand_sig;
    logic [SIG_W-1:0] multiplier_sig;

    modport source (
        output valid, sign, invalid, exponent, multiplicand_sig, multiplier_sig
    );

    modport sink (
        input valid, sign, invalid, exponent, multiplicand_sig, multiplier_sig
    );

endinterface : fpm_stage0_if

// ----------------------------------------
// Product stage to normalizer
// ----------------------------------------
interface fpm_stage1_if
    import fpm_pipe_pkg::*;
();

    logic      valid;
    logic      sign;
    logic      invalid;
    // Exponent still unadjusted for the product carry
    exp_work_t exponent;
    product_t  product;

    modport source (
        output valid, sign, invalid, exponent, product
    );

    modport sink (
        input valid, sign, invalid, exponent, product
    );

endinterface : fpm_stage1_if

//--- common/fpm_pipe_pkg.sv
// ----------------------------------------
// Multiplier pipeline types
// Working exponent, product width and
// the operand class encoding
// ----------------------------------------

package fpm_pipe_pkg;

    import fp_format_pkg::*;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Full significand product, two 24-bit factors
    localparam int PROD_W = 2 * SIG_W;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    // Signed working exponent, two extra bits
    // Covers ea + eb - bias from -125 up to 381 plus the carry increment
    typedef logic signed [EXP_W+1:0] exp_work_t;

    // Raw product, binary point between bits 46 and 45
    typedef logic [PROD_W-1:0] product_t;

    // Operand classes, only CLASS_NORMAL is accepted as a valid operand
    typedef enum logic [2:0] {
        CLASS_NORMAL,
        CLASS_ZERO,
        CLASS_SUBNORMAL,
        CLASS_INFINITY,
        CLASS_NAN
    } operand_class_e;

endpackage : fpm_pipe_pkg

//--- common/fp_format_pkg.sv
// ----------------------------------------
// IEEE 754 single-precision format
// Field widths, bias and the float and
// round-bit types used at the ports
// ----------------------------------------

package fp_format_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------

    // Biased exponent field
    localparam int EXP_W = 8;
    // Stored significand, hidden bit excluded
    localparam int MANT_W = 23;
    // Significand with the hidden bit
    localparam int SIG_W = MANT_W + 1;

    // ----------------------------------------
    // Exponent constants
    // ----------------------------------------

    localparam int BIAS = 127;
    // All-ones exponent, reserved for infinity and NaN
    localparam int EXP_MAX = (1 << EXP_W) - 1;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    // Packed float, sign in bit 31
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] significand;
    } float32_t;

    // Bits below the stored significand, kept for a later rounding unit
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

endpackage : fp_format_pkg
